// File: hdl/mipsPkg.sv
// ----------------------------------------------------------
// mipsPkg
// shared widths, opcodes, funct codes and control encodings
// for the single-cycle MIPS core
// ----------------------------------------------------------
`default_nettype none

package mipsPkg;

	// datapath widths
	localparam int wordW = 32;
	localparam int regAddrW = 5;
	// jal link register
	localparam int linkReg = 31;

	// main opcode field, instr[31:26]
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ = 6'h02,
		opJal = 6'h03,
		opBeq = 6'h04,
		opAddi = 6'h08,
		opSubi = 6'h09,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcodeT;

	// R-type funct field, instr[5:0]
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnSlt = 6'h2a
	} functT;

	// request from main decoder to the alu
	typedef enum logic [1:0] {aluOpAdd, aluOpSub, aluOpFunct} aluOpT;
	// operation actually done by the alu
	typedef enum logic [2:0] {fAdd, fSub, fAnd, fOr, fSlt} aluFuncT;
	// write register select
	typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstT;
	// write-back source select
	typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSrcT;

endpackage

`default_nettype wire

// File: hdl/ctrlIf.sv
// ----------------------------------------------------------
// ctrlIf
// decoded control lines from the main decoder to datapath
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface ctrlIf import mipsPkg::*; ();
	logic aluSrc;
	regDstT regDst;
	logic memWrite;
	logic memRead;
	logic beq;
	logic jump;
	wbSrcT wbSrc;
	logic regWrite;
	aluOpT aluOp;

	modport decoder (output aluSrc, regDst, memWrite, memRead, beq, jump, wbSrc, regWrite, aluOp);
	modport datapath (input aluSrc, regDst, memWrite, memRead, beq, jump, wbSrc, regWrite, aluOp);
endinterface

`default_nettype wire

// File: hdl/control.sv
// ----------------------------------------------------------
// control
// main decoder, maps the opcode onto the nine control lines
// unknown opcodes fall through as a no-op
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module control import mipsPkg::*; (
	input opcodeT opcode,
	ctrlIf.decoder ctrl
);

	always_comb begin
		// all-zero defaults, nothing written, no memory access
		ctrl.aluSrc = 1'b0;
		ctrl.regDst = dstRt;
		ctrl.memWrite = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.beq = 1'b0;
		ctrl.jump = 1'b0;
		ctrl.wbSrc = wbAlu;
		ctrl.regWrite = 1'b0;
		ctrl.aluOp = aluOpAdd;

		case (opcode)
			opRType: begin
				// both operands from registers, alu decodes funct
				ctrl.regDst = dstRd;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluOpFunct;
			end
			opLw: begin
				// address is rs + imm
				ctrl.aluSrc = 1'b1;
				ctrl.regDst = dstRt;
				ctrl.memRead = 1'b1;
				ctrl.wbSrc = wbMem;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluOpAdd;
			end
			opSw: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluOp = aluOpAdd;
			end
			opBeq: begin
				// rs - rt, zero flag decides the branch
				ctrl.beq = 1'b1;
				ctrl.aluOp = aluOpSub;
			end
			opJ: begin
				ctrl.jump = 1'b1;
			end
			opJal: begin
				// link pc+4 into r31
				ctrl.jump = 1'b1;
				ctrl.regDst = dstRa;
				ctrl.wbSrc = wbLink;
				ctrl.regWrite = 1'b1;
			end
			opAddi: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regDst = dstRt;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluOpAdd;
			end
			opSubi: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regDst = dstRt;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluOpSub;
			end
			default: begin
				// keep the no-op defaults
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/alu.sv
// ----------------------------------------------------------
// alu
// local function decode from aluOp and funct, then
// add, sub, and, or, signed slt plus the zero flag
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module alu import mipsPkg::*; (
	input aluOpT aluOp,
	input functT funct,
	input logic [wordW-1:0] a,
	input logic [wordW-1:0] b,
	output logic [wordW-1:0] result,
	output logic zero
);

	aluFuncT funcOp;
	logic funcValid;
	logic [wordW-1:0] rawResult;

	// function decode
	always_comb begin
		funcOp = fAdd;
		funcValid = 1'b1;
		case (aluOp)
			aluOpAdd: funcOp = fAdd;
			aluOpSub: funcOp = fSub;
			aluOpFunct: begin
				case (funct)
					fnAdd: funcOp = fAdd;
					fnSub: funcOp = fSub;
					fnAnd: funcOp = fAnd;
					fnOr: funcOp = fOr;
					fnSlt: funcOp = fSlt;
					// unsupported funct gives zero
					default: funcValid = 1'b0;
				endcase
			end
			default: funcValid = 1'b0;
		endcase
	end

	always_comb begin
		case (funcOp)
			fAdd: rawResult = a + b;
			fSub: rawResult = a - b;
			fAnd: rawResult = a & b;
			fOr: rawResult = a | b;
			// signed compare, 1 or 0
			fSlt: rawResult = {{(wordW-1){1'b0}}, $signed(a) < $signed(b)};
			default: rawResult = '0;
		endcase
	end

	assign result = funcValid ? rawResult : '0;
	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hdl/regFile.sv
// ----------------------------------------------------------
// regFile
// 32 x 32 registers, two async read ports, one write port
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module regFile import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input logic [regAddrW-1:0] readAddrA,
	input logic [regAddrW-1:0] readAddrB,
	input logic [regAddrW-1:0] writeAddr,
	input logic writeEn,
	input logic [wordW-1:0] writeData,
	output logic [wordW-1:0] readDataA,
	output logic [wordW-1:0] readDataB
);

	logic [wordW-1:0] regs [2**regAddrW];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 2**regAddrW; i++) regs[i] <= '0;
		end else if (writeEn && writeAddr != '0) begin
			// r0 never takes a write
			regs[writeAddr] <= writeData;
		end
	end

	// r0 hardwired to zero
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

// File: hdl/dataPath.sv
// ----------------------------------------------------------
// dataPath
// pc and next-pc logic, operand and write-back muxes,
// register file and alu of the single-cycle core
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module dataPath import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input logic [wordW-1:0] instr,
	ctrlIf.datapath ctrl,
	output logic [wordW-1:0] instrAddr,
	output logic [wordW-1:0] dataAddr,
	output logic [wordW-1:0] dataWdata,
	input logic [wordW-1:0] dataRdata,
	output logic dataWrite,
	output logic dataRead
);

	logic [wordW-1:0] pc;
	logic [wordW-1:0] pcPlus4;
	logic [wordW-1:0] nextPc;
	logic [wordW-1:0] branchTarget;
	logic [wordW-1:0] jumpTarget;
	logic [wordW-1:0] signExt;
	logic [wordW-1:0] readDataA;
	logic [wordW-1:0] readDataB;
	logic [wordW-1:0] aluB;
	logic [wordW-1:0] aluResult;
	logic [wordW-1:0] writeData;
	logic [regAddrW-1:0] writeReg;
	logic aluZero;
	logic takeBranch;

	// pc, one step per clock
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) pc <= '0;
		else pc <= nextPc;
	end

	assign pcPlus4 = pc + 32'd4;
	// 16-bit immediate, sign extended
	assign signExt = {{(wordW-16){instr[15]}}, instr[15:0]};
	assign branchTarget = pcPlus4 + (signExt << 2);
	// upper pc bits kept from pc+4
	assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};
	// beq taken when rs - rt is zero
	assign takeBranch = ctrl.beq & aluZero;

	always_comb begin
		if (ctrl.jump) nextPc = jumpTarget;
		else if (takeBranch) nextPc = branchTarget;
		else nextPc = pcPlus4;
	end

	// second alu operand
	assign aluB = ctrl.aluSrc ? signExt : readDataB;

	// destination register
	always_comb begin
		case (ctrl.regDst)
			dstRd: writeReg = instr[15:11];
			dstRa: writeReg = regAddrW'(linkReg);
			default: writeReg = instr[20:16];
		endcase
	end

	// write-back source
	always_comb begin
		case (ctrl.wbSrc)
			wbMem: writeData = dataRdata;
			wbLink: writeData = pcPlus4;
			default: writeData = aluResult;
		endcase
	end

	regFile regFile_inst (
		.clk(clk),
		.arstN(arstN),
		.readAddrA(instr[25:21]),
		.readAddrB(instr[20:16]),
		.writeAddr(writeReg),
		.writeEn(ctrl.regWrite),
		.writeData(writeData),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	alu alu_inst (
		.aluOp(ctrl.aluOp),
		.funct(functT'(instr[5:0])),
		.a(readDataA),
		.b(aluB),
		.result(aluResult),
		.zero(aluZero)
	);

	// memory side
	assign instrAddr = pc;
	assign dataAddr = aluResult;
	assign dataWdata = readDataB;
	// strobes held low while arstN is asserted
	assign dataWrite = ctrl.memWrite & arstN;
	assign dataRead = ctrl.memRead & arstN;

endmodule

`default_nettype wire

// File: hdl/mipsCore.sv
// ----------------------------------------------------------
// mipsCore
// single-cycle MIPS top, decoder plus datapath with plain
// instruction and data memory ports
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mipsCore import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	output logic [wordW-1:0] instrAddr,
	input logic [wordW-1:0] instr,
	output logic [wordW-1:0] dataAddr,
	output logic [wordW-1:0] dataWdata,
	output logic dataWrite,
	output logic dataRead,
	input logic [wordW-1:0] dataRdata
);

	// decoded control lines
	ctrlIf ctrl ();

	control control_inst (
		.opcode(opcodeT'(instr[31:26])),
		.ctrl(ctrl)
	);

	dataPath dataPath_inst (
		.clk(clk),
		.arstN(arstN),
		.instr(instr),
		.ctrl(ctrl),
		.instrAddr(instrAddr),
		.dataAddr(dataAddr),
		.dataWdata(dataWdata),
		.dataRdata(dataRdata),
		.dataWrite(dataWrite),
		.dataRead(dataRead)
	);

endmodule

`default_nettype wire

// File: testbench/tbClock.sv
// ----------------------------------------------------------
// tbClock
// 40 ns clock and active-low reset, held for three rising
// edges at start and again on each reset request
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tbClock (
	output logic clk,
	output logic arstN,
	input logic resetReq
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		arstN = 1'b0;
		forever begin
			// release 1 ns after the third rising edge
			repeat (3) @(posedge clk);
			#1;
			arstN = 1'b1;
			@(posedge resetReq);
			arstN = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: testbench/tbMips.sv
// ----------------------------------------------------------
// tbMips
// directed tests of the single-cycle MIPS core, with
// combinational instruction and data memory models
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tbMips import mipsPkg::*; ();

	logic clk;
	logic arstN;
	logic resetReq;
	logic [wordW-1:0] instrAddr;
	logic [wordW-1:0] instr;
	logic [wordW-1:0] dataAddr;
	logic [wordW-1:0] dataWdata;
	logic dataWrite;
	logic dataRead;
	logic [wordW-1:0] dataRdata;

	// 256 words each, indexed by address bits 9:2
	logic [wordW-1:0] imem [256];
	logic [wordW-1:0] dmem [256];
	logic [wordW-1:0] prog [$];
	logic [wordW-1:0] pcTrace [$];
	logic [wordW-1:0] expPc [$];
	logic [31:0] lfsrState;
	int errorCount;
	int testsPassed;
	int testsFailed;
	int storeCount;
	int readCount;

	tbClock tbClock_inst (.clk(clk), .arstN(arstN), .resetReq(resetReq));

	mipsCore mipsCore_inst (
		.clk(clk),
		.arstN(arstN),
		.instrAddr(instrAddr),
		.instr(instr),
		.dataAddr(dataAddr),
		.dataWdata(dataWdata),
		.dataWrite(dataWrite),
		.dataRead(dataRead),
		.dataRdata(dataRdata)
	);

	// both memories answer in the same cycle
	assign instr = imem[instrAddr[9:2]];
	assign dataRdata = dmem[dataAddr[9:2]];

	function automatic logic [31:0] rType(input logic [4:0] rs, rt, rd, input functT fn);
		return {opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iType(input opcodeT op, input logic [4:0] rs, rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jType(input opcodeT op, input logic [25:0] target);
		return {op, target};
	endfunction

	function automatic logic [31:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// untouched data words read back as this
	function automatic logic [31:0] fillWord(input logic [31:0] addr);
		return 32'hd00d0000 | addr;
	endfunction

	function automatic logic [31:0] memWord(input logic [31:0] addr);
		return dmem[addr[9:2]];
	endfunction

	// right-shift galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = galoisStep(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	task automatic checkWord(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkTrace();
		if (pcTrace.size() != expPc.size()) begin
			errorCount++;
			$display("pc trace holds %0d entries instead of %0d", pcTrace.size(), expPc.size());
		end else begin
			foreach (expPc[i]) checkWord($sformatf("instrAddr[%0d]", i), expPc[i], pcTrace[i]);
		end
	endtask

	task automatic closeTest(input string name, input int startErrors);
		if (errorCount == startErrors) begin
			testsPassed++;
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", name, errorCount - startErrors);
		end
	endtask

	task automatic loadProgram();
		for (int i = 0; i < 256; i++) begin
			// opcode 0x3f is unknown to the decoder, so a no-op
			imem[8'(i)] = {6'h3f, 26'(i)};
			dmem[8'(i)] = fillWord(32'(i * 4));
		end
		foreach (prog[i]) imem[8'(i)] = prog[i];
		pcTrace = {};
		storeCount = 0;
		readCount = 0;
	endtask

	task automatic pulseReset(input bit checkHold);
		resetReq = 1'b1;
		@(posedge clk);
		#1;
		resetReq = 1'b0;
		// two low phases of the three-cycle reset are left
		repeat (2) begin
			@(negedge clk);
			if (checkHold) begin
				if (arstN !== 1'b0) begin
					errorCount++;
					$display("reset was released early, at %0d ns", $time);
				end
				checkWord("instrAddr", 32'd0, instrAddr);
				checkWord("dataWrite", 32'd0, 32'(dataWrite));
			end
		end
		@(posedge arstN);
	endtask

	task automatic runCycles(input int n);
		logic doWrite;
		logic [7:0] idx;
		logic [wordW-1:0] wdata;
		repeat (n) begin
			// sample in the low phase, store lands just after the edge
			@(negedge clk);
			pcTrace.push_back(instrAddr);
			if (dataRead === 1'b1) readCount++;
			doWrite = dataWrite;
			idx = dataAddr[9:2];
			wdata = dataWdata;
			@(posedge clk);
			#1;
			if (doWrite) begin
				dmem[idx] = wdata;
				storeCount++;
			end
		end
	endtask

	task automatic resetSequence();
		int startErrors;
		startErrors = errorCount;
		// a store waits at word 0 while reset is held
		prog = {};
		prog.push_back(iType(opSw, 5'd0, 5'd0, 16'h00c0));
		loadProgram();
		pulseReset(1'b1);
		runCycles(8);
		expPc = {};
		for (int i = 0; i < 8; i++) expPc.push_back(32'(i * 4));
		checkTrace();
		checkWord("dmem[0xc0]", 32'd0, memWord(32'hc0));
		checkWord("store count", 32'd1, 32'(storeCount));
		closeTest("reset", startErrors);
	endtask

	task automatic arithmeticOps();
		int startErrors;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] want [$];
		startErrors = errorCount;
		a = sext16(16'd1234);
		b = a - sext16(16'd500);
		want = {};
		want.push_back(a);
		want.push_back(b);
		want.push_back(a + b);
		want.push_back(b - a);
		want.push_back(a & b);
		want.push_back(a | b);
		want.push_back(($signed(b - a) < $signed(a)) ? 32'd1 : 32'd0);
		want.push_back(($signed(a) < $signed(b - a)) ? 32'd1 : 32'd0);
		want.push_back(32'd0);
		prog = {};
		prog.push_back(iType(opAddi, 5'd0, 5'd1, 16'd1234));
		prog.push_back(iType(opSubi, 5'd1, 5'd2, 16'd500));
		prog.push_back(rType(5'd1, 5'd2, 5'd3, fnAdd));
		prog.push_back(rType(5'd2, 5'd1, 5'd4, fnSub));
		prog.push_back(rType(5'd1, 5'd2, 5'd5, fnAnd));
		prog.push_back(rType(5'd1, 5'd2, 5'd6, fnOr));
		prog.push_back(rType(5'd4, 5'd1, 5'd7, fnSlt));
		prog.push_back(rType(5'd1, 5'd4, 5'd8, fnSlt));
		// write to r0, must be dropped
		prog.push_back(iType(opAddi, 5'd0, 5'd0, 16'd99));
		// r1..r8 then r0 to 0x100..0x120
		for (int r = 1; r <= 9; r++) prog.push_back(iType(opSw, 5'd0, 5'(r % 9), 16'(252 + 4 * r)));
		loadProgram();
		pulseReset(1'b0);
		runCycles(18);
		for (int r = 1; r <= 9; r++)
			checkWord($sformatf("dmem[0x%0h]", 252 + 4 * r), want[r - 1], memWord(32'(252 + 4 * r)));
		closeTest("arithmetic", startErrors);
	endtask

	task automatic loadStore();
		int startErrors;
		startErrors = errorCount;
		prog = {};
		prog.push_back(iType(opAddi, 5'd0, 5'd1, 16'h0040));
		prog.push_back(iType(opAddi, 5'd0, 5'd2, 16'hfb2e));
		// 0x40 + 8, then read back and copy to 0x4c
		prog.push_back(iType(opSw, 5'd1, 5'd2, 16'h0008));
		prog.push_back(iType(opLw, 5'd1, 5'd3, 16'h0008));
		prog.push_back(iType(opSw, 5'd1, 5'd3, 16'h000c));
		loadProgram();
		pulseReset(1'b0);
		runCycles(5);
		checkWord("dmem[0x48]", sext16(16'hfb2e), memWord(32'h48));
		checkWord("dmem[0x4c]", sext16(16'hfb2e), memWord(32'h4c));
		// only the lw raises dataRead
		checkWord("read count", 32'd1, 32'(readCount));
		checkWord("store count", 32'd2, 32'(storeCount));
		closeTest("load store", startErrors);
	endtask

	task automatic branchOps();
		int startErrors;
		startErrors = errorCount;
		prog = {};
		prog.push_back(iType(opAddi, 5'd0, 5'd1, 16'd5));
		prog.push_back(iType(opAddi, 5'd0, 5'd2, 16'd5));
		prog.push_back(iType(opAddi, 5'd0, 5'd3, 16'd9));
		// equal, lands at 16 + 4
		prog.push_back(iType(opBeq, 5'd1, 5'd2, 16'd1));
		prog.push_back(iType(opSw, 5'd0, 5'd1, 16'h0080));
		// unequal, falls through
		prog.push_back(iType(opBeq, 5'd1, 5'd3, 16'd1));
		prog.push_back(iType(opSw, 5'd0, 5'd3, 16'h0084));
		loadProgram();
		pulseReset(1'b0);
		runCycles(8);
		expPc = {};
		expPc.push_back(32'd0);
		expPc.push_back(32'd4);
		expPc.push_back(32'd8);
		expPc.push_back(32'd12);
		expPc.push_back(32'd20);
		expPc.push_back(32'd24);
		expPc.push_back(32'd28);
		expPc.push_back(32'd32);
		checkTrace();
		checkWord("dmem[0x80]", fillWord(32'h80), memWord(32'h80));
		checkWord("dmem[0x84]", 32'd9, memWord(32'h84));
		checkWord("store count", 32'd1, 32'(storeCount));
		closeTest("branch", startErrors);
	endtask

	task automatic jumpOps();
		int startErrors;
		startErrors = errorCount;
		prog = {};
		prog.push_back(iType(opAddi, 5'd0, 5'd1, 16'd77));
		// j to word 3, skips the store at 8
		prog.push_back(jType(opJ, 26'd3));
		prog.push_back(iType(opSw, 5'd0, 5'd1, 16'h0090));
		// jal at 12 to word 6, links 16
		prog.push_back(jType(opJal, 26'd6));
		prog.push_back(iType(opSw, 5'd0, 5'd1, 16'h0094));
		prog.push_back(rType(5'd0, 5'd0, 5'd0, fnAdd));
		prog.push_back(iType(opSw, 5'd0, 5'(linkReg), 16'h0098));
		loadProgram();
		pulseReset(1'b0);
		runCycles(6);
		expPc = {};
		expPc.push_back(32'd0);
		expPc.push_back(32'd4);
		expPc.push_back(32'd12);
		expPc.push_back(32'd24);
		expPc.push_back(32'd28);
		expPc.push_back(32'd32);
		checkTrace();
		checkWord("dmem[0x90]", fillWord(32'h90), memWord(32'h90));
		checkWord("dmem[0x94]", fillWord(32'h94), memWord(32'h94));
		checkWord("dmem[0x98]", 32'd12 + 32'd4, memWord(32'h98));
		closeTest("jump", startErrors);
	endtask

	task automatic randomChain();
		int startErrors;
		logic [31:0] model;
		logic [31:0] draw;
		logic [15:0] imm;
		logic useSub;
		startErrors = errorCount;
		model = '0;
		prog = {};
		// twelve steps on r1, sixteen immediate bits and one op bit each
		for (int k = 0; k < 12; k++) begin
			draw = randomBits(17);
			imm = draw[15:0];
			useSub = draw[16];
			if (useSub) model = model - sext16(imm);
			else model = model + sext16(imm);
			prog.push_back(iType(useSub ? opSubi : opAddi, 5'd1, 5'd1, imm));
		end
		prog.push_back(iType(opSw, 5'd0, 5'd1, 16'h00a0));
		loadProgram();
		pulseReset(1'b0);
		runCycles(13);
		checkWord("dmem[0xa0]", model, memWord(32'ha0));
		closeTest("random", startErrors);
	endtask

	initial begin
		resetReq = 1'b0;
		errorCount = 0;
		testsPassed = 0;
		testsFailed = 0;
		storeCount = 0;
		readCount = 0;
		lfsrState = 32'h6d82574f;
		prog = {};
		loadProgram();
		wait (arstN === 1'b1);
		@(posedge clk);
		#1;
		resetSequence();
		arithmeticOps();
		loadStore();
		branchOps();
		jumpOps();
		randomChain();
		$display("tests passed: %0d, failed: %0d", testsPassed, testsFailed);
		if (testsFailed == 0 && errorCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// watchdog, run cycles of all tests plus about five per reset and a margin
	initial begin
		int budget;
		budget = (8 + 18 + 5 + 8 + 6 + 13 + 6 * 5 + 20) * 40;
		#(budget);
		$display("timeout, the tests did not finish within %0d ns", budget);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
hdl/mipsPkg.sv
hdl/ctrlIf.sv
hdl/control.sv
hdl/alu.sv
hdl/regFile.sv
hdl/dataPath.sv
hdl/mipsCore.sv
testbench/tbClock.sv
testbench/tbMips.sv

// File: run.sh
#!/usr/bin/env bash
# builds the MIPS core testbench with Verilator, runs it into a log
# and decides pass or fail from the log

cd "$(dirname "$0")" || exit 1

objDir=obj_dir
logFile=sim.log

verilator --binary --timing --top-module tbMips --Mdir "$objDir" -o simMips -f all.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "verilator build failed with status $buildStatus"
	exit 1
fi

"./$objDir/simMips" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "sim passed" "$logFile"; then
	exit 0
fi
exit 1
